//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    // RV32I memory operations carried with each instruction
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        cmd_nop   = 2'd0,
        cmd_read  = 2'd1,
        cmd_write = 2'd2
    } mem_cmd_e;

    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_mem      = 2'd1,
        wb_pc_plus4 = 2'd2  // link address for jal and jalr
    } wb_sel_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_out;   // doubles as the memory address
        logic [31:0] rs2_data;
        mem_op_e     mem_op;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_out;
        logic [31:0] read_data;  // already extended for loads
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  rd;
    } mem_wb_t;

    typedef struct packed {
        mem_cmd_e    cmd;
        logic [31:0] addr;
        logic [31:0] wdata;  // already shifted into its byte lanes
        logic [3:0]  wmask;
    } mem_req_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } rf_write_t;

endpackage

`default_nettype wire

//--- verilog/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  ex_mem_t in_data,
    input  logic    stall,
    output logic    ex_valid,
    output ex_mem_t ex_data
);

    logic    valid_q;
    ex_mem_t data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;  // a bubble is loaded as well
        end
    end

    // the memory stage reads this record for the whole access
    always_ff @(posedge clk) begin
        if (!stall) begin
            data_q <= in_data;
        end
    end

    assign ex_valid = valid_q;
    assign ex_data  = data_q;

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ex_valid,
    input  ex_mem_t     ex_data,
    output logic        stall,
    output mem_req_t    req,
    input  logic        cmd_ready,
    input  logic [31:0] rdata,
    input  logic        rdata_valid,
    output logic        wb_valid,
    output mem_wb_t     wb_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ready,
        st_wait_read
    } state_e;

    state_e      state;
    state_e      state_next;
    logic        is_load;
    logic        is_store;
    logic        mem_access;
    logic        accepted;
    logic        retire;
    logic [1:0]  lane;
    logic [31:0] load_word;
    logic [31:0] load_data;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (ex_data.mem_op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu: is_load = 1'b1;
            op_sb, op_sh, op_sw:                 is_store = 1'b1;
            default:                             is_load = 1'b0;
        endcase
    end

    assign mem_access = ex_valid && (is_load || is_store);
    assign lane       = ex_data.alu_out[1:0];  // aligned accesses assumed

    // the command comes straight from the held record, the register upstream is stalled
    always_comb begin
        req.addr  = ex_data.alu_out;
        req.wdata = ex_data.rs2_data << {lane, 3'b000};
        case (ex_data.mem_op)
            op_sb:   req.wmask = 4'b0001 << lane;
            op_sh:   req.wmask = 4'b0011 << lane;  // lane is 0 or 2
            op_sw:   req.wmask = 4'b1111;
            default: req.wmask = 4'b0000;
        endcase
        if (!mem_access || state == st_wait_read) begin
            req.cmd = cmd_nop;
        end else if (is_store) begin
            req.cmd = cmd_write;
        end else begin
            req.cmd = cmd_read;
        end
    end

    assign accepted = (req.cmd != cmd_nop) && cmd_ready;

    // a load holds the pipeline from issue until its data returns
    always_comb begin
        if (state == st_wait_read) begin
            stall = !rdata_valid;
        end else begin
            stall = mem_access && (!cmd_ready || is_load);
        end
    end

    assign retire = ex_valid && !stall;  // the instruction leaves this stage now

    always_comb begin
        state_next = state;
        case (state)
            st_idle, st_wait_ready: begin
                if (!mem_access) begin
                    state_next = st_idle;
                end else if (!accepted) begin
                    state_next = st_wait_ready;
                end else if (is_load) begin
                    state_next = st_wait_read;
                end else begin
                    state_next = st_idle;
                end
            end
            st_wait_read: begin
                if (rdata_valid) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    assign load_word = rdata >> {lane, 3'b000};  // bring the addressed bytes down to bit 0

    always_comb begin
        case (ex_data.mem_op)
            op_lb:   load_data = {{24{load_word[7]}}, load_word[7:0]};
            op_lbu:  load_data = {24'd0, load_word[7:0]};
            op_lh:   load_data = {{16{load_word[15]}}, load_word[15:0]};
            op_lhu:  load_data = {16'd0, load_word[15:0]};
            op_lw:   load_data = load_word;
            default: load_data = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            wb_valid <= 1'b0;
        end else begin
            state    <= state_next;
            wb_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wb_data.pc        <= ex_data.pc;
            wb_data.alu_out   <= ex_data.alu_out;
            wb_data.read_data <= (state == st_wait_read) ? load_data : 32'd0;
            wb_data.rf_wen    <= ex_data.rf_wen;
            wb_data.wb_sel    <= ex_data.wb_sel;
            wb_data.rd        <= ex_data.rd;
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory
    import core_pkg::*;
#(
    parameter int MEM_WORDS    = 256,
    parameter int READY_GAP    = 1,
    parameter int READ_LATENCY = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    req,
    output logic        cmd_ready,
    output logic [31:0] rdata,
    output logic        rdata_valid
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int GAP_W = $clog2(READY_GAP + 2);
    localparam int LAT_W = $clog2(READ_LATENCY + 2);

    logic [31:0]      mem [MEM_WORDS] = '{default: 32'd0};
    logic [IDX_W-1:0] idx;
    logic [GAP_W-1:0] gap_cnt;
    logic [LAT_W-1:0] lat_cnt;
    logic [31:0]      read_word;
    logic             accept;
    logic             accept_read;
    logic             accept_write;

    // the low two address bits select a byte lane and do not take part in the index
    assign idx = IDX_W'(req.addr[31:2] % MEM_WORDS);

    assign accept       = (req.cmd != cmd_nop) && cmd_ready;
    assign accept_read  = accept && (req.cmd == cmd_read);
    assign accept_write = accept && (req.cmd == cmd_write);

    always_ff @(posedge clk) begin
        if (accept_write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        if (accept_read) begin
            read_word <= mem[idx];  // held until the next read
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gap_cnt <= '0;
            lat_cnt <= '0;
        end else begin
            if (accept) begin
                gap_cnt <= GAP_W'(READY_GAP);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
            if (accept_read) begin
                lat_cnt <= LAT_W'(READ_LATENCY);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    assign cmd_ready   = (gap_cnt == '0);
    assign rdata_valid = (lat_cnt == LAT_W'(1));  // last count of the read delay
    assign rdata       = read_word;

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_valid,
    input  mem_wb_t   wb_data,
    output rf_write_t rf_write
);

    logic [31:0] wb_value;
    logic        wr_en;
    logic [4:0]  wr_rd;
    logic [31:0] wr_data;

    always_comb begin
        case (wb_data.wb_sel)
            wb_alu:      wb_value = wb_data.alu_out;
            wb_mem:      wb_value = wb_data.read_data;
            wb_pc_plus4: wb_value = wb_data.pc + 32'd4;
            default:     wb_value = wb_data.alu_out;
        endcase
    end

    // x0 is hardwired to zero so its writes are dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= wb_valid && wb_data.rf_wen && (wb_data.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            wr_rd   <= wb_data.rd;
            wr_data <= wb_value;
        end
    end

    assign rf_write.en   = wr_en;
    assign rf_write.rd   = wr_rd;
    assign rf_write.data = wr_data;

endmodule

`default_nettype wire

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
    import core_pkg::*;
#(
    parameter int MEM_WORDS    = 256,
    parameter int READY_GAP    = 1,
    parameter int READ_LATENCY = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  ex_mem_t   in_data,
    output logic      stall,
    output rf_write_t rf_write
);

    logic        ex_valid;
    ex_mem_t     ex_data;
    mem_req_t    req;
    logic        cmd_ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        wb_valid;
    mem_wb_t     wb_data;

    ex_mem_reg u_ex_mem_reg (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .stall    (stall),
        .ex_valid (ex_valid),
        .ex_data  (ex_data)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .ex_valid    (ex_valid),
        .ex_data     (ex_data),
        .stall       (stall),
        .req         (req),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data)
    );

    data_memory #(
        .MEM_WORDS    (MEM_WORDS),
        .READY_GAP    (READY_GAP),
        .READ_LATENCY (READ_LATENCY)
    ) u_data_memory (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    writeback_stage u_writeback_stage (
        .clk      (clk),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .rf_write (rf_write)
    );

endmodule

`default_nettype wire

//--- tb/mem_subsystem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_checker
    import core_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     ex_valid,
    input ex_mem_t  ex_data,
    input logic     stall,
    input mem_req_t req,
    input logic     cmd_ready,
    input logic     rdata_valid,
    input logic     wb_valid
);

    logic load_in_stage;

    assign load_in_stage = ex_valid &&
                           (ex_data.mem_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu});

    // a waiting command keeps address, data and mask until the memory takes it
    req_stable_a: assert property (@(posedge clk) disable iff (rst)
        (req.cmd != cmd_nop && !cmd_ready) |=> $stable(req))
        else $error("memory command changed while waiting for cmd_ready");

    stall_cause_a: assert property (@(posedge clk) disable iff (rst)
        stall |-> (ex_valid && ex_data.mem_op != op_none))
        else $error("stall is high without a memory instruction in the stage");

    // a load hands one result to writeback, on the cycle after its read data returns
    load_wait_pulse_a: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && $past(load_in_stage)) |-> $past(rdata_valid))
        else $error("wb_valid rose for a load that was still waiting for read data");

endmodule

bind mem_stage mem_subsystem_checker u_mem_subsystem_checker (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_data     (ex_data),
    .stall       (stall),
    .req         (req),
    .cmd_ready   (cmd_ready),
    .rdata_valid (rdata_valid),
    .wb_valid    (wb_valid)
);

`default_nettype wire

//--- tb/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
    import core_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    ex_mem_t     in_data;
    logic        stall;
    rf_write_t   rf_write;
    ex_mem_t     stim[$];
    rf_write_t   expected[$];
    logic [7:0]  ref_mem [1024];  // byte image of the 256-word data memory
    integer      seed = 32'h51e8ba61;
    int          n_got = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    mem_subsystem #(
        .MEM_WORDS    (256),
        .READY_GAP    (1),
        .READ_LATENCY (2)
    ) u_mem_subsystem (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .stall    (stall),
        .rf_write (rf_write)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error: time %0t, %s = %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error: time %0t, %s = %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_write(input rf_write_t got, input rf_write_t exp);
        if (got.rd !== exp.rd) begin
            stop_with_failure($sformatf("error: time %0t, rf_write.rd = %0d, expected %0d",
                                        $time, got.rd, exp.rd));
        end else begin
            check_word("rf_write.data", got.data, exp.data);
        end
    endtask

    task automatic add_instr(input logic [31:0] addr, input logic [31:0] rs2, input mem_op_e op,
                             input logic wen, input wb_sel_e sel, input logic [4:0] rd);
        logic [31:0] pc;
        pc = 32'h0000_0100 + 32'(4 * stim.size());
        stim.push_back(ex_mem_t'{pc, addr, rs2, op, wen, sel, rd});
    endtask

    task automatic build_table();
        add_instr(32'h1111_1111, 32'h0, op_none, 1'b1, wb_alu, 5'd1);
        add_instr(32'h0000_0abc, 32'h0, op_none, 1'b1, wb_pc_plus4, 5'd2);
        add_instr(32'h2222_2222, 32'h0, op_none, 1'b1, wb_alu, 5'd0);  // x0, no write
        add_instr(32'h3333_3333, 32'h0, op_none, 1'b0, wb_alu, 5'd3);
        add_instr(32'h4444_4444, 32'h0, op_none, 1'b1, wb_alu, 5'd3);
        add_instr(32'h0000_0040, 32'hdead_beef, op_sw, 1'b0, wb_alu, 5'd9);
        add_instr(32'h0000_0040, 32'h0, op_lw, 1'b1, wb_mem, 5'd4);
        // a nonzero background shows any lane that a narrow store touches by mistake
        add_instr(32'h0000_0080, 32'h5a5a_5a5a, op_sw, 1'b0, wb_alu, 5'd0);
        // upper rs2 bits must not leak into neighbouring lanes
        add_instr(32'h0000_0080, 32'hffff_ffa1, op_sb, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0082, 32'h0000_0093, op_sb, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0080, 32'h0, op_lw, 1'b1, wb_mem, 5'd7);
        add_instr(32'h0000_0081, 32'h1234_5672, op_sb, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0083, 32'haaaa_aaf4, op_sb, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0080, 32'h0, op_lw, 1'b1, wb_mem, 5'd5);
        add_instr(32'h0000_0084, 32'h5a5a_5a5a, op_sw, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0084, 32'hffff_8123, op_sh, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0084, 32'h0, op_lw, 1'b1, wb_mem, 5'd12);
        add_instr(32'h0000_0086, 32'h0000_7fee, op_sh, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0084, 32'h0, op_lw, 1'b1, wb_mem, 5'd6);
        add_instr(32'h0000_0080, 32'h0, op_lb, 1'b1, wb_mem, 5'd8);
        add_instr(32'h0000_0080, 32'h0, op_lbu, 1'b1, wb_mem, 5'd9);
        add_instr(32'h0000_0081, 32'h0, op_lb, 1'b1, wb_mem, 5'd10);
        add_instr(32'h0000_0081, 32'h0, op_lbu, 1'b1, wb_mem, 5'd16);
        add_instr(32'h0000_0082, 32'h0, op_lb, 1'b1, wb_mem, 5'd19);
        add_instr(32'h0000_0083, 32'h0, op_lbu, 1'b1, wb_mem, 5'd11);
        add_instr(32'h0000_0084, 32'h0, op_lh, 1'b1, wb_mem, 5'd13);
        add_instr(32'h0000_0084, 32'h0, op_lhu, 1'b1, wb_mem, 5'd14);
        add_instr(32'h0000_0086, 32'h0, op_lh, 1'b1, wb_mem, 5'd15);
        add_instr(32'h0000_0086, 32'h0, op_lhu, 1'b1, wb_mem, 5'd20);
        add_instr(32'h0000_0100, 32'h0bad_f00d, op_sw, 1'b0, wb_alu, 5'd0);
        add_instr(32'h5555_0000, 32'h0, op_none, 1'b1, wb_alu, 5'd17);
        add_instr(32'h0000_0102, 32'h8765_c3c3, op_sh, 1'b0, wb_alu, 5'd0);
        add_instr(32'h0000_0100, 32'h0, op_lw, 1'b1, wb_mem, 5'd18);
        add_instr(32'h0000_0010, 32'h0, op_lb, 1'b1, wb_mem, 5'd0);
        add_instr(32'h0000_0440, 32'h0, op_lw, 1'b1, wb_mem, 5'd22);  // wraps onto 0x40
        add_instr(32'h0000_0000, 32'h0, op_none, 1'b1, wb_pc_plus4, 5'd31);
    endtask

    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
        logic [9:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        a  = addr[9:0];
        b0 = ref_mem[a];
        b1 = ref_mem[a + 10'd1];
        case (op)
            op_lb:   return {{24{b0[7]}}, b0};
            op_lbu:  return {24'd0, b0};
            op_lh:   return {{16{b1[7]}}, b1, b0};
            op_lhu:  return {16'd0, b1, b0};
            op_lw:   return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], b1, b0};
            default: return 32'd0;
        endcase
    endfunction

    task automatic ref_store(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        int n;
        n = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[addr[9:0] + 10'(i)] = data[8*i +: 8];
        end
    endtask

    task automatic build_expected();
        rf_write_t   w;
        logic [31:0] rd_data;
        foreach (stim[i]) begin
            rd_data = 32'd0;
            if (stim[i].mem_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu}) begin
                rd_data = ref_load(stim[i].mem_op, stim[i].alu_out);
            end else if (stim[i].mem_op inside {op_sb, op_sh, op_sw}) begin
                ref_store(stim[i].mem_op, stim[i].alu_out, stim[i].rs2_data);
            end
            if (stim[i].rf_wen && stim[i].rd != 5'd0) begin
                w.en = 1'b1;
                w.rd = stim[i].rd;
                case (stim[i].wb_sel)
                    wb_mem:      w.data = rd_data;
                    wb_pc_plus4: w.data = stim[i].pc + 32'd4;
                    default:     w.data = stim[i].alu_out;
                endcase
                expected.push_back(w);
            end
        end
    endtask

    // holds the record until an edge with stall low takes it
    task automatic send(input ex_mem_t rec);
        logic taken;
        in_valid = 1'b1;
        in_data  = rec;
        do begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            #1;
        end while (!taken);
        in_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rf_write.en === 1'b1) begin
            if (n_got >= expected.size()) begin
                stop_with_failure("the design wrote a register more often than the stream asks");
            end else begin
                check_write(rf_write, expected[n_got]);
                n_got++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_with_failure("timeout, the design stopped retiring instructions");
        end
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = 8'd0;
        end
        build_table();
        build_expected();
        cycle_limit = 40 * stim.size() + 50;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_bit("rf_write.en", rf_write.en, 1'b0);
            check_bit("stall", stall, 1'b0);
        end
        @(posedge clk);
        #1;
        foreach (stim[i]) begin
            if (($random(seed) & 3) == 0) begin
                @(posedge clk);  // one idle cycle on the input
                #1;
            end
            send(stim[i]);
        end
        wait (n_got == expected.size());
        repeat (20) @(posedge clk);  // a late extra write would still reach the monitor here
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/core_pkg.sv
verilog/ex_mem_reg.sv
verilog/mem_stage.sv
verilog/data_memory.sv
verilog/writeback_stage.sv
verilog/mem_subsystem.sv
tb/mem_subsystem_checker.sv
tb/mem_subsystem_tb.sv
